/* include/alu_defines.svh */
////////////////////////////////////////////////////////////////////////////
// width macros for the packed-SIMD ALU datapath
////////////////////////////////////////////////////////////////////////////

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand width in bits, a multiple of 32
`define ALU_OP_W 64

// number of bytes per operand
`define ALU_BYTES (`ALU_OP_W / 8)

// operand width in 9-bit-per-byte form
// every byte carries one carry-chain bit below its data bits
`define ALU_WIDE_W (`ALU_OP_W * 9 / 8)

`endif

/* hdl/alu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// opcode and element-width enums, pipeline control struct
////////////////////////////////////////////////////////////////////////////

package alu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SEQ,
        ALU_SNE,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        EEW_8,
        EEW_16,
        EEW_32
    } alu_eew_e;

    // control word that follows each transaction through the stages
    typedef struct packed {
        alu_op_e  op;
        alu_eew_e eew;
    } alu_ctrl_t;

    // ops that compute b - a in the adder (a is inverted, carry-in set)
    function automatic logic alu_is_sub(alu_op_e op);
        return op inside {ALU_SUB, ALU_SEQ, ALU_SNE, ALU_SLT, ALU_SLTU};
    endfunction

endpackage

/* hdl/alu_stage_if.sv */
////////////////////////////////////////////////////////////////////////////
// stage-to-stage bundles of the ALU pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

// operand preparation to arithmetic/shift stage
interface alu_ex1_if import alu_pkg::*; ();

    logic                   valid;
    logic                   ready;
    alu_ctrl_t              ctrl;
    logic [`ALU_WIDE_W-1:0] wide_a;
    logic [`ALU_WIDE_W-1:0] wide_b;

    modport src (
        output valid, ctrl, wide_a, wide_b,
        input  ready
    );

    modport dst (
        input  valid, ctrl, wide_a, wide_b,
        output ready
    );

endinterface

// arithmetic/shift stage to result selection
interface alu_ex2_if import alu_pkg::*; ();

    logic                  valid;
    logic                  ready;
    alu_ctrl_t             ctrl;
    logic [`ALU_OP_W-1:0]  sum;
    logic [`ALU_BYTES-1:0] lt;
    logic [`ALU_OP_W-1:0]  shift_res;
    logic [`ALU_OP_W-1:0]  a;
    logic [`ALU_OP_W-1:0]  b;

    modport src (
        output valid, ctrl, sum, lt, shift_res, a, b,
        input  ready
    );

    modport dst (
        input  valid, ctrl, sum, lt, shift_res, a, b,
        output ready
    );

endinterface

/* hdl/alu_operand_prep.sv */
////////////////////////////////////////////////////////////////////////////
// stage 1: 9-bit-per-byte operand build with carry-chain bits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_operand_prep import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  alu_ctrl_t            in_ctrl_i,
    input  logic [`ALU_OP_W-1:0] in_op1_i,
    input  logic [`ALU_OP_W-1:0] in_op2_i,

    alu_ex1_if.src               ex1
);

    logic                   sub;
    logic [`ALU_BYTES-1:0]  elem_low;
    logic [`ALU_WIDE_W-1:0] wide_a_d;
    logic [`ALU_WIDE_W-1:0] wide_b_d;

    assign sub = alu_is_sub(in_ctrl_i.op);

    // marks the lowest byte of every element for the current width
    always_comb begin
        for (int i = 0; i < `ALU_BYTES; i++) begin
            unique case (in_ctrl_i.eew)
                EEW_8:   elem_low[i] = 1'b1;
                EEW_16:  elem_low[i] = (i % 2) == 0;
                default: elem_low[i] = (i % 4) == 0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // operand spreading

    // data bytes sit above their chain bit, operand a is inverted for b - a
    always_comb begin
        for (int i = 0; i < `ALU_BYTES; i++) begin
            wide_a_d[9*i+1 +: 8] = in_op1_i[8*i +: 8] ^ {8{sub}};
            wide_b_d[9*i+1 +: 8] = in_op2_i[8*i +: 8];
            if (elem_low[i]) begin
                // equal chain bits kill any carry from the element below and
                // inject the subtract carry-in into this element
                wide_a_d[9*i] = sub;
                wide_b_d[9*i] = sub;
            end else begin
                // one plus zero propagates the incoming carry unchanged
                wide_a_d[9*i] = 1'b1;
                wide_b_d[9*i] = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage register

    assign in_ready_o = ~ex1.valid | ex1.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ex1.valid <= 1'b0;
        end else if (in_ready_o) begin
            ex1.valid <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            ex1.ctrl   <= in_ctrl_i;
            ex1.wide_a <= wide_a_d;
            ex1.wide_b <= wide_b_d;
        end
    end

endmodule

/* hdl/alu_arith_shift.sv */
////////////////////////////////////////////////////////////////////////////
// stage 2: fracturable adder, less-than flags and barrel shifter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_arith_shift import alu_pkg::*; (
    input  logic   clk_i,
    input  logic   async_rst_ni,

    alu_ex1_if.dst ex1,
    alu_ex2_if.src ex2
);

    // each 36-bit group holds four bytes and one 32-bit element at most
    localparam int GROUPS = `ALU_OP_W / 32;

    logic                  sub;
    logic                  is_ltu;
    logic [36:0]           sum37 [GROUPS];
    logic [`ALU_OP_W-1:0]  sum_d;
    logic [`ALU_OP_W-1:0]  a_pk;
    logic [`ALU_OP_W-1:0]  b_pk;
    logic [`ALU_OP_W-1:0]  shift_d;
    logic [`ALU_BYTES-1:0] carry;
    logic [`ALU_BYTES-1:0] sig_a;
    logic [`ALU_BYTES-1:0] sig_b;
    logic [`ALU_BYTES-1:0] sig_res;
    logic [`ALU_BYTES-1:0] ovflw;
    logic [`ALU_BYTES-1:0] lt_byte;
    logic [`ALU_BYTES-1:0] lt_d;

    assign sub    = alu_is_sub(ex1.ctrl.op);
    assign is_ltu = ex1.ctrl.op == ALU_SLTU;

    ////////////////////////////////////////////////////////////////////////////
    // fracturable adder

    always_comb begin
        for (int g = 0; g < GROUPS; g++) begin
            sum37[g] = {1'b0, ex1.wide_b[36*g +: 36]} + {1'b0, ex1.wide_a[36*g +: 36]};
        end
    end

    // per-byte taps, only meaningful at the top byte of an element
    // the bit above a byte is the next chain position or the group carry-out
    always_comb begin
        for (int i = 0; i < `ALU_BYTES; i++) begin
            sum_d[8*i +: 8] = sum37[i/4][9*(i%4)+1 +: 8];
            carry[i]        = sum37[i/4][9*(i%4)+9];
            sig_res[i]      = sum37[i/4][9*(i%4)+8];
            sig_a[i]        = ex1.wide_a[9*i+8];
            sig_b[i]        = ex1.wide_b[9*i+8];
            a_pk[8*i +: 8]  = ex1.wide_a[9*i+1 +: 8] ^ {8{sub}};
            b_pk[8*i +: 8]  = ex1.wide_b[9*i+1 +: 8];
        end
    end

    // overflow follows the addition rule since a was inverted beforehand
    assign ovflw   = ~(sig_a ^ sig_b) & (sig_a ^ sig_res);
    assign lt_byte = is_ltu ? ~carry : (ovflw ^ sig_res);

    // spread the flag of each element's top byte over the whole element
    always_comb begin
        for (int i = 0; i < `ALU_BYTES; i++) begin
            unique case (ex1.ctrl.eew)
                EEW_8:   lt_d[i] = lt_byte[i];
                EEW_16:  lt_d[i] = lt_byte[i | 1];
                default: lt_d[i] = lt_byte[i | 3];
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // barrel shifter, one lane set per element width

    for (genvar k = 0; k < 3; k++) begin : g_width
        localparam int W  = 8 << k;
        localparam int SH = 3 + k;

        logic [`ALU_OP_W-1:0] res;

        always_comb begin
            logic [SH-1:0]     amt;
            logic              fill;
            logic signed [W:0] right;
            for (int e = 0; e < `ALU_OP_W / W; e++) begin
                amt   = a_pk[W*e +: SH];
                fill  = (ex1.ctrl.op == ALU_SRA) & b_pk[W*e+W-1];
                right = $signed({fill, b_pk[W*e +: W]}) >>> amt;
                if (ex1.ctrl.op == ALU_SLL) begin
                    res[W*e +: W] = b_pk[W*e +: W] << amt;
                end else begin
                    res[W*e +: W] = right[W-1:0];
                end
            end
        end
    end

    always_comb begin
        unique case (ex1.ctrl.eew)
            EEW_8:   shift_d = g_width[0].res;
            EEW_16:  shift_d = g_width[1].res;
            default: shift_d = g_width[2].res;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage register

    assign ex1.ready = ~ex2.valid | ex2.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ex2.valid <= 1'b0;
        end else if (ex1.ready) begin
            ex2.valid <= ex1.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex1.ready && ex1.valid) begin
            ex2.ctrl      <= ex1.ctrl;
            ex2.sum       <= sum_d;
            ex2.lt        <= lt_d;
            ex2.shift_res <= shift_d;
            ex2.a         <= a_pk;
            ex2.b         <= b_pk;
        end
    end

endmodule

/* hdl/alu_result_sel.sv */
////////////////////////////////////////////////////////////////////////////
// stage 3: equality detection, result and flag select, output register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_result_sel import alu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    alu_ex2_if.dst                ex2,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic [`ALU_OP_W-1:0]  out_res_o,
    output logic [`ALU_BYTES-1:0] out_cmp_o
);

    logic [`ALU_BYTES-1:0] zero;
    logic [`ALU_OP_W-1:0]  res_d;
    logic [`ALU_BYTES-1:0] cmp_d;

    // b - a is zero over the whole element exactly when b equals a
    always_comb begin
        for (int i = 0; i < `ALU_BYTES; i++) begin
            unique case (ex2.ctrl.eew)
                EEW_8:   zero[i] = ex2.sum[8*i +: 8] == '0;
                EEW_16:  zero[i] = ex2.sum[16*(i/2) +: 16] == '0;
                default: zero[i] = ex2.sum[32*(i/4) +: 32] == '0;
            endcase
        end
    end

    always_comb begin
        unique case (ex2.ctrl.op)
            ALU_AND:                   res_d = ex2.b & ex2.a;
            ALU_OR:                    res_d = ex2.b | ex2.a;
            ALU_XOR:                   res_d = ex2.b ^ ex2.a;
            ALU_SLL, ALU_SRL, ALU_SRA: res_d = ex2.shift_res;
            // add, subtract and all compares return the adder output
            default:                   res_d = ex2.sum;
        endcase
    end

    always_comb begin
        unique case (ex2.ctrl.op)
            ALU_SEQ:           cmp_d = zero;
            ALU_SNE:           cmp_d = ~zero;
            ALU_SLT, ALU_SLTU: cmp_d = ex2.lt;
            default:           cmp_d = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register

    assign ex2.ready = ~out_valid_o | out_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            out_valid_o <= 1'b0;
        end else if (ex2.ready) begin
            out_valid_o <= ex2.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex2.ready && ex2.valid) begin
            out_res_o <= res_d;
            out_cmp_o <= cmp_d;
        end
    end

endmodule

/* hdl/alu_top.sv */
////////////////////////////////////////////////////////////////////////////
// top level of the three-stage packed-SIMD ALU
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_top import alu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  alu_op_e               in_op_i,
    input  alu_eew_e              in_eew_i,
    input  logic [`ALU_OP_W-1:0]  in_op1_i,
    input  logic [`ALU_OP_W-1:0]  in_op2_i,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic [`ALU_OP_W-1:0]  out_res_o,
    output logic [`ALU_BYTES-1:0] out_cmp_o
);

    alu_ctrl_t in_ctrl;

    assign in_ctrl = '{op: in_op_i, eew: in_eew_i};

    alu_ex1_if ex1_bus ();
    alu_ex2_if ex2_bus ();

    alu_operand_prep u_operand_prep (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_ctrl_i    (in_ctrl),
        .in_op1_i     (in_op1_i),
        .in_op2_i     (in_op2_i),
        .ex1          (ex1_bus)
    );

    alu_arith_shift u_arith_shift (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ex1          (ex1_bus),
        .ex2          (ex2_bus)
    );

    alu_result_sel u_result_sel (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ex2          (ex2_bus),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_res_o    (out_res_o),
        .out_cmp_o    (out_cmp_o)
    );

endmodule

/* verification/alu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the packed-SIMD ALU with LFSR stimulus, reference model,
// in-order scoreboard with latency check and a cycle timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_tb import alu_pkg::*; ();

    localparam int NUM_FIXED   = 300;
    localparam int NUM_RANDOM  = 100;
    localparam int CYCLE_LIMIT = (NUM_FIXED + NUM_RANDOM) * 8 + 50;

    typedef struct packed {
        logic [`ALU_OP_W-1:0]  res;
        logic [`ALU_BYTES-1:0] cmp;
        logic [31:0]           acc_cycle;
        logic                  fixed_ready;
    } expect_t;

    logic                  clk_i;
    logic                  async_rst_ni;
    logic                  in_valid_i;
    logic                  in_ready_o;
    alu_op_e               in_op_i;
    alu_eew_e              in_eew_i;
    logic [`ALU_OP_W-1:0]  in_op1_i;
    logic [`ALU_OP_W-1:0]  in_op2_i;
    logic                  out_valid_o;
    logic                  out_ready_i;
    logic [`ALU_OP_W-1:0]  out_res_o;
    logic [`ALU_BYTES-1:0] out_cmp_o;

    logic [31:0] lfsr_state;
    int          cycle_cnt;
    logic        ready_fixed;
    expect_t     exp_q [$];

    alu_top uut (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_eew_i     (in_eew_i),
        .in_op1_i     (in_op1_i),
        .in_op2_i     (in_op2_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_res_o    (out_res_o),
        .out_cmp_o    (out_cmp_o)
    );

    always #50 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // Galois LFSR stepped once per bit taken with the newest bit landing in bit 0
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] bits;
        logic        lsb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            bits = {bits[62:0], lsb};
        end
        return bits;
    endfunction

    function automatic logic [63:0] sign_extend(input logic [63:0] v, input int w);
        logic [63:0] mask;
        mask = (64'd1 << w) - 64'd1;
        return v[w-1] ? (v | ~mask) : v;
    endfunction

    // reference model that works element by element with b as the left operand
    task automatic model_result(input alu_op_e op, input alu_eew_e eew,
                                input logic [63:0] a, input logic [63:0] b,
                                output logic [63:0] res, output logic [7:0] cmp);
        int          w;
        int          sh;
        logic [63:0] mask;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] r;
        logic        flag;
        w    = 8 << int'(eew);
        mask = (64'd1 << w) - 64'd1;
        res  = '0;
        cmp  = '0;
        for (int e = 0; e < 64 / w; e++) begin
            ea   = (a >> (w * e)) & mask;
            eb   = (b >> (w * e)) & mask;
            sa   = sign_extend(ea, w);
            sb   = sign_extend(eb, w);
            sh   = int'(ea & 64'(w - 1));
            flag = 1'b0;
            case (op)
                ALU_ADD: r = eb + ea;
                ALU_SUB: r = eb - ea;
                ALU_AND: r = eb & ea;
                ALU_OR:  r = eb | ea;
                ALU_XOR: r = eb ^ ea;
                ALU_SLL: r = eb << sh;
                ALU_SRL: r = eb >> sh;
                ALU_SRA: r = $signed(sb) >>> sh;
                default: begin
                    r = eb - ea;
                    case (op)
                        ALU_SEQ:  flag = eb == ea;
                        ALU_SNE:  flag = eb != ea;
                        ALU_SLT:  flag = $signed(sb) < $signed(sa);
                        default:  flag = eb < ea;
                    endcase
                end
            endcase
            res = res | ((r & mask) << (w * e));
            for (int k = 0; k < w / 8; k++) begin
                cmp[(w / 8) * e + k] = flag;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    // one in eight forces carries, one in eight borrows, one in eight equal operands
    task automatic pick_inputs();
        logic [63:0] a;
        logic [63:0] b;
        logic [2:0]  mode;
        a    = lfsr_bits(64);
        b    = lfsr_bits(64);
        mode = 3'(lfsr_bits(3));
        if (mode == 3'd0) begin
            b = '1;
            a = a & 64'h0303_0303_0303_0303;
        end else if (mode == 3'd1) begin
            b = '0;
            a = a & 64'h0303_0303_0303_0303;
        end else if (mode == 3'd2) begin
            a = b;
        end
        in_op_i  <= alu_op_e'(4'(lfsr_bits(4) % 12));
        in_eew_i <= alu_eew_e'(2'(lfsr_bits(2) % 3));
        in_op1_i <= a;
        in_op2_i <= b;
    endtask

    task automatic run_phase(input int count, input bit rand_ready);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(posedge clk_i);
            if (in_valid_i && in_ready_o) begin
                sent++;
            end
            if (!in_valid_i || in_ready_o) begin
                if (sent < count && lfsr_bits(2) != 64'd0) begin
                    in_valid_i <= 1'b1;
                    pick_inputs();
                end else begin
                    in_valid_i <= 1'b0;
                end
            end
            out_ready_i <= rand_ready ? lfsr_bits(1) != 64'd0 : 1'b1;
        end
    endtask

    task automatic drain_pipeline();
        @(posedge clk_i);
        out_ready_i <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scoreboard and timeout

    always @(posedge clk_i) begin : scoreboard
        expect_t               ent;
        logic [`ALU_OP_W-1:0]  res;
        logic [`ALU_BYTES-1:0] cmp;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles",
                                CYCLE_LIMIT));
        end else if (async_rst_ni) begin
            if (in_valid_i && in_ready_o) begin
                model_result(in_op_i, in_eew_i, in_op1_i, in_op2_i, res, cmp);
                exp_q.push_back('{res: res, cmp: cmp, acc_cycle: 32'(cycle_cnt),
                                  fixed_ready: ready_fixed});
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("output transfer seen with no transaction pending");
                end else begin
                    ent = exp_q.pop_front();
                    compare_values("out_res_o", out_res_o, ent.res);
                    compare_values("out_cmp_o", 64'(out_cmp_o), 64'(ent.cmp));
                    if (ent.fixed_ready) begin
                        compare_values("latency", 64'(cycle_cnt) - 64'(ent.acc_cycle),
                                       64'd3);
                    end
                end
            end
        end
    end

    initial begin
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b1;
        in_op_i      = ALU_ADD;
        in_eew_i     = EEW_8;
        in_op1_i     = '0;
        in_op2_i     = '0;
        out_ready_i  = 1'b0;
        lfsr_state   = 32'hf499_653f;
        cycle_cnt    = 0;
        ready_fixed  = 1'b1;

        // a transaction is offered against a stalled output during reset
        // and the pipeline must stay empty and open all the same
        repeat (8) begin
            @(negedge clk_i);
            compare_values("out_valid_o", 64'(out_valid_o), 64'd0);
            compare_values("in_ready_o", 64'(in_ready_o), 64'd1);
        end
        @(posedge clk_i);
        async_rst_ni <= 1'b1;
        in_valid_i   <= 1'b0;
        out_ready_i  <= 1'b1;
        @(negedge clk_i);
        compare_values("out_valid_o", 64'(out_valid_o), 64'd0);
        compare_values("in_ready_o", 64'(in_ready_o), 64'd1);

        run_phase(NUM_FIXED, 1'b0);
        drain_pipeline();
        ready_fixed = 1'b0;
        run_phase(NUM_RANDOM, 1'b1);
        drain_pipeline();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hdl/alu_pkg.sv
hdl/alu_stage_if.sv
hdl/alu_operand_prep.sv
hdl/alu_arith_shift.sv
hdl/alu_result_sel.sv
hdl/alu_top.sv
verification/alu_tb.sv

/* Makefile */
# Verilator build and run for the packed-SIMD ALU

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= alu_tb
LINT_TOP  ?= alu_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
